// ==== hdl/astro_cfg_pkg.sv ====
// Game configuration definitions
package astro_cfg_pkg;

	// ============================================================
	// Game identity
	// ============================================================

	// Mode byte as it arrives from the download
	typedef logic [7:0] game_id_t;

	// One-hot game flags, bit 0 Space Zap, bit 1 WoW, bit 2 Gorf
	typedef logic [2:0] game_flags_t;

	localparam game_id_t GAME_SPACEZAP = 8'd3;
	localparam game_id_t GAME_GORF     = 8'd4;
	localparam game_id_t GAME_WOW      = 8'd5;

	// Bit positions inside game_flags_t
	localparam int FLAG_SPACEZAP = 0;
	localparam int FLAG_WOW      = 1;
	localparam int FLAG_GORF     = 2;

	// ============================================================
	// Download port
	// ============================================================

	// Download indexes
	localparam logic [7:0] IDX_MODE = 8'd1;
	localparam logic [7:0] IDX_DIP  = 8'd254;

	typedef logic [24:0] dl_addr_t;
	typedef logic [15:0] dl_data_t;

	// DIP switch banks
	typedef logic [7:0] dip_byte_t;
	typedef logic [2:0] dip_addr_t;
	localparam int DIP_BANKS = 8;

endpackage

// ==== hdl/astro_input_pkg.sv ====
// Player input definitions
package astro_input_pkg;

	// ============================================================
	// Buttons and joystick
	// ============================================================

	// Per-player buttons, low bits line up with the joystick word
	typedef logic [5:0] btn_t;
	localparam int BTN_RIGHT  = 0;
	localparam int BTN_LEFT   = 1;
	localparam int BTN_DOWN   = 2;
	localparam int BTN_UP     = 3;
	localparam int BTN_FIRE   = 4;
	localparam int BTN_FIRE_B = 5;

	// USB joystick word, bits 5..0 as btn_t
	typedef logic [8:0] joy_word_t;
	localparam int JOY_START1 = 6;
	localparam int JOY_START2 = 7;
	localparam int JOY_COIN   = 8;

	// ============================================================
	// PS/2 key events
	// ============================================================

	// Toggle, pressed, 9-bit code
	typedef logic [10:0] ps2_event_t;
	localparam int PS2_TOGGLE  = 10;
	localparam int PS2_PRESSED = 9;

	// Arrows are extended codes, matched on low byte only
	localparam logic [8:0] KEY_UP    = 9'h175;
	localparam logic [8:0] KEY_DOWN  = 9'h172;
	localparam logic [8:0] KEY_LEFT  = 9'h16B;
	localparam logic [8:0] KEY_RIGHT = 9'h174;
	localparam logic [8:0] KEY_SPACE = 9'h029;
	localparam logic [8:0] KEY_CTRL  = 9'h014;
	localparam logic [8:0] KEY_F1    = 9'h005;
	localparam logic [8:0] KEY_F2    = 9'h006;
	localparam logic [8:0] KEY_F3    = 9'h004;
	// Arcade panel style keys
	localparam logic [8:0] KEY_1     = 9'h016;
	localparam logic [8:0] KEY_2     = 9'h01E;
	localparam logic [8:0] KEY_5     = 9'h02E;
	localparam logic [8:0] KEY_R     = 9'h02D;
	localparam logic [8:0] KEY_F     = 9'h02B;
	localparam logic [8:0] KEY_D     = 9'h023;
	localparam logic [8:0] KEY_G     = 9'h034;
	localparam logic [8:0] KEY_A     = 9'h01C;
	localparam logic [8:0] KEY_S     = 9'h01B;

	// ============================================================
	// Analog sticks and switch matrix
	// ============================================================

	// Two signed bytes, X low and Y high
	typedef logic [15:0] analog_t;
	typedef logic [2:0] zone_t;

	// Mapper result
	typedef logic [2:0] wow_dir_t;
	localparam int WOW_DIR0 = 0;
	localparam int WOW_DIR1 = 1;
	localparam int WOW_MOVE = 2;

	localparam int NUM_AXES  = 4;
	localparam int AXIS_P1_Y = 0;
	localparam int AXIS_P1_X = 1;
	localparam int AXIS_P2_Y = 2;
	localparam int AXIS_P2_X = 3;

	typedef logic [7:0] col_t;
	typedef logic [7:0] row_t;
	localparam col_t COL_CT0  = 8'h01;
	localparam col_t COL_CT1  = 8'h02;
	localparam col_t COL_CT2  = 8'h04;
	localparam col_t COL_CT3  = 8'h08;
	localparam row_t ROW_IDLE = 8'hFF;

endpackage

// ==== hdl/player_buttons_if.sv ====
// Merged player buttons
`timescale 1ns/10ps

interface player_buttons_if import astro_input_pkg::*; ();

	// Both players, active high
	btn_t p1;
	btn_t p2;

	// Shared panel buttons
	logic start1;
	logic start2;
	logic coin;

	// Key decoder side
	modport src (
		output p1, p2, start1, start2, coin
	);

	// Switch matrix side
	modport dst (
		input p1, p2, start1, start2, coin
	);

endinterface

// ==== hdl/game_config.sv ====
// Game mode and DIP banks
`timescale 1ns/10ps

module game_config import astro_cfg_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  logic        dl_wr,
	input  logic [7:0]  dl_index,
	input  dl_addr_t    dl_addr,
	input  dl_data_t    dl_data,
	output game_flags_t game_flags,
	output dip_byte_t   dip0,
	output dip_byte_t   dip2,
	output dip_byte_t   dip3
);

	game_id_t  mode_q;
	dip_byte_t dip_q [DIP_BANKS];
	dip_addr_t dip_addr;
	logic      dip_wr;

	// Only the first eight addresses reach the banks
	assign dip_addr = dl_addr[2:0];
	assign dip_wr   = dl_wr && (dl_index == IDX_DIP) && (dl_addr < dl_addr_t'(DIP_BANKS));

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			mode_q     <= '0;
			game_flags <= '0;
			for (int i = 0; i < DIP_BANKS; i++) begin
				dip_q[i] <= '0;
			end
		end else begin
			if (dl_wr && (dl_index == IDX_MODE)) begin
				mode_q <= dl_data[7:0];
			end
			// Decode stage, one cycle behind the mode byte
			game_flags <= '0;
			case (mode_q)
				GAME_SPACEZAP: game_flags[FLAG_SPACEZAP] <= 1'b1;
				GAME_WOW:      game_flags[FLAG_WOW]      <= 1'b1;
				GAME_GORF:     game_flags[FLAG_GORF]     <= 1'b1;
				default:       ;
			endcase
			if (dip_wr) begin
				dip_q[dip_addr] <= dl_data[7:0];
			end
		end
	end

	// Matrix reads banks 0, 2 and 3
	assign dip0 = dip_q[0];
	assign dip2 = dip_q[2];
	assign dip3 = dip_q[3];

	// At most one game selected
	a_flags_onehot: assert property (@(posedge clk_sys) disable iff (reset)
		$onehot0(game_flags));

endmodule

// ==== hdl/key_decoder.sv ====
// PS/2 key and joystick merge
`timescale 1ns/10ps

module key_decoder import astro_input_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  ps2_event_t ps2_key,
	input  joy_word_t  joy_p1,
	input  joy_word_t  joy_p2,
	player_buttons_if.src btns
);

	logic       toggle_q;
	logic       key_event;
	logic       key_pressed;
	logic [8:0] key_code;

	// Key latches for 12 stick keys and 6 panel keys
	btn_t p1_keys;
	btn_t p2_keys;
	logic key_f1, key_1;
	logic key_f2, key_2;
	logic key_f3, key_5;

	assign key_event   = ps2_key[PS2_TOGGLE] != toggle_q;
	assign key_pressed = ps2_key[PS2_PRESSED];
	assign key_code    = ps2_key[8:0];

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			toggle_q <= 1'b0;
			p1_keys  <= '0;
			p2_keys  <= '0;
			key_f1   <= 1'b0;
			key_1    <= 1'b0;
			key_f2   <= 1'b0;
			key_2    <= 1'b0;
			key_f3   <= 1'b0;
			key_5    <= 1'b0;
		end else begin
			toggle_q <= ps2_key[PS2_TOGGLE];
			if (key_event) begin
				// Arrow keys match with the extended prefix ignored
				case (key_code[7:0])
					KEY_UP[7:0]:    p1_keys[BTN_UP]    <= key_pressed;
					KEY_DOWN[7:0]:  p1_keys[BTN_DOWN]  <= key_pressed;
					KEY_LEFT[7:0]:  p1_keys[BTN_LEFT]  <= key_pressed;
					KEY_RIGHT[7:0]: p1_keys[BTN_RIGHT] <= key_pressed;
					default:        ;
				endcase
				case (key_code)
					KEY_CTRL:  p1_keys[BTN_FIRE]   <= key_pressed;
					KEY_SPACE: p1_keys[BTN_FIRE_B] <= key_pressed;
					KEY_F1:    key_f1 <= key_pressed;
					KEY_F2:    key_f2 <= key_pressed;
					KEY_F3:    key_f3 <= key_pressed;
					KEY_1:     key_1  <= key_pressed;
					KEY_2:     key_2  <= key_pressed;
					KEY_5:     key_5  <= key_pressed;
					// Player 2 block
					KEY_R:     p2_keys[BTN_UP]     <= key_pressed;
					KEY_F:     p2_keys[BTN_DOWN]   <= key_pressed;
					KEY_D:     p2_keys[BTN_LEFT]   <= key_pressed;
					KEY_G:     p2_keys[BTN_RIGHT]  <= key_pressed;
					KEY_A:     p2_keys[BTN_FIRE]   <= key_pressed;
					KEY_S:     p2_keys[BTN_FIRE_B] <= key_pressed;
					default:   ;
				endcase
			end
		end
	end

	// Combinational merge with joystick words
	assign btns.p1     = p1_keys | btn_t'(joy_p1[5:0]);
	assign btns.p2     = p2_keys | btn_t'(joy_p2[5:0]);
	assign btns.start1 = key_f1 | key_1 | joy_p1[JOY_START1];
	assign btns.start2 = key_f2 | key_2 | joy_p1[JOY_START2];
	assign btns.coin   = key_f3 | key_5 | joy_p1[JOY_COIN];

endmodule

// ==== hdl/paddle_shaper.sv ====
// Analog stick centring
`timescale 1ns/10ps

module paddle_shaper import astro_input_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  analog_t               analog_a,
	input  analog_t               analog_b,
	output zone_t [NUM_AXES-1:0]  zones
);

	// Centred bytes, 0 full one way and FF full the other
	logic [7:0] p1_y_c;
	logic [7:0] p1_x_c;
	logic [7:0] p2_y_c;
	logic [7:0] p2_x_c;

	// Y axes are flipped before the offset
	assign p1_y_c = ~analog_a[15:8] + 8'd128;
	assign p1_x_c = analog_a[7:0] + 8'd128;
	assign p2_y_c = ~analog_b[15:8] + 8'd128;
	assign p2_x_c = analog_b[7:0] + 8'd128;

	// Zone is the top three bits
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			zones <= '0;
		end else begin
			zones[AXIS_P1_Y] <= p1_y_c[7:5];
			zones[AXIS_P1_X] <= p1_x_c[7:5];
			zones[AXIS_P2_Y] <= p2_y_c[7:5];
			zones[AXIS_P2_X] <= p2_x_c[7:5];
		end
	end

endmodule

// ==== hdl/wow_axis_mapper.sv ====
// Wizard of Wor axis mapper
`timescale 1ns/10ps

module wow_axis_mapper import astro_input_pkg::*; (
	input  logic     clk_sys,
	input  logic     reset,
	input  zone_t    zone,
	output wow_dir_t dir
);

	// Outer zones also press move, centre band is dead
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			dir <= '0;
		end else begin
			dir <= '0;
			case (zone)
				3'd0: begin
					dir[WOW_DIR0] <= 1'b1;
					dir[WOW_MOVE] <= 1'b1;
				end
				3'd1: dir[WOW_DIR0] <= 1'b1;
				3'd6: dir[WOW_DIR1] <= 1'b1;
				3'd7: begin
					dir[WOW_DIR1] <= 1'b1;
					dir[WOW_MOVE] <= 1'b1;
				end
				default: ;
			endcase
		end
	end

	a_dir_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(dir[WOW_DIR0] && dir[WOW_DIR1]));

endmodule

// ==== hdl/switch_matrix.sv ====
// CPU switch matrix
`timescale 1ns/10ps

module switch_matrix import astro_cfg_pkg::*, astro_input_pkg::*; (
	input  game_flags_t              game_flags,
	input  dip_byte_t                dip0,
	input  dip_byte_t                dip2,
	input  dip_byte_t                dip3,
	input  logic                     speech_busy,
	input  col_t                     col_select,
	input  wow_dir_t [NUM_AXES-1:0]  axis_dirs,
	player_buttons_if.dst            btns,
	output row_t                     row_data
);

	// Active-low right, left, down, up
	function automatic logic [3:0] key_dirs(input btn_t b);
		return ~{b[BTN_RIGHT], b[BTN_LEFT], b[BTN_DOWN], b[BTN_UP]};
	endfunction

	// Same order from a Y and an X mapper
	function automatic logic [3:0] stick_dirs(input wow_dir_t y, input wow_dir_t x);
		return ~{x[WOW_DIR1], x[WOW_DIR0], y[WOW_DIR0], y[WOW_DIR1]};
	endfunction

	row_t ct0_sz, ct1_sz, ct2_sz;
	row_t ct0_ww, ct1_ww, ct2_ww;
	row_t ct0_gf, ct1_gf, ct2_gf;
	logic w1_move;
	logic w2_move;

	// Either axis far enough out counts as move
	assign w1_move = axis_dirs[AXIS_P1_Y][WOW_MOVE] | axis_dirs[AXIS_P1_X][WOW_MOVE];
	assign w2_move = axis_dirs[AXIS_P2_Y][WOW_MOVE] | axis_dirs[AXIS_P2_X][WOW_MOVE];

	// ============================================================
	// Per-game row bytes
	// ============================================================

	// Space Zap
	assign ct0_sz = {2'b11, ~btns.start2, ~btns.start1, dip2[1], 1'b1, ~btns.coin, 1'b1};
	assign ct1_sz = {3'b111, ~btns.p2[BTN_FIRE], key_dirs(btns.p2)};
	assign ct2_sz = {2'b11, dip2[0], ~btns.p1[BTN_FIRE], key_dirs(btns.p1)};

	// Wizard of Wor, fire_b stays active high in key mode
	assign ct0_ww = {dip2[2], ~btns.start2, ~btns.start1, 1'b1, dip2[1], 1'b1, ~btns.coin, 1'b1};
	assign ct1_ww = dip0[1] ?
		{2'b11, ~btns.p2[BTN_FIRE], ~w2_move,
			stick_dirs(axis_dirs[AXIS_P2_Y], axis_dirs[AXIS_P2_X])} :
		{2'b11, ~btns.p2[BTN_FIRE], btns.p2[BTN_FIRE_B], key_dirs(btns.p2)};
	assign ct2_ww = dip0[0] ?
		{speech_busy, 1'b1, ~btns.p1[BTN_FIRE], ~w1_move,
			stick_dirs(axis_dirs[AXIS_P1_Y], axis_dirs[AXIS_P1_X])} :
		{speech_busy, 1'b1, ~btns.p1[BTN_FIRE], btns.p1[BTN_FIRE_B], key_dirs(btns.p1)};

	// Gorf
	assign ct0_gf = {dip2[2], dip2[0], ~btns.start2, ~btns.start1, 1'b1, dip2[1], ~btns.coin, 1'b1};
	assign ct1_gf = {3'b001, ~btns.p2[BTN_FIRE], key_dirs(btns.p2)};
	assign ct2_gf = {speech_busy, 2'b01, ~btns.p1[BTN_FIRE], key_dirs(btns.p1)};

	// ============================================================
	// Column select
	// ============================================================

	always_comb begin
		row_data = ROW_IDLE;
		case (col_select)
			COL_CT0: begin
				if (game_flags[FLAG_SPACEZAP]) row_data = ct0_sz;
				else if (game_flags[FLAG_WOW]) row_data = ct0_ww;
				else if (game_flags[FLAG_GORF]) row_data = ct0_gf;
			end
			COL_CT1: begin
				if (game_flags[FLAG_SPACEZAP]) row_data = ct1_sz;
				else if (game_flags[FLAG_WOW]) row_data = ct1_ww;
				else if (game_flags[FLAG_GORF]) row_data = ct1_gf;
			end
			COL_CT2: begin
				if (game_flags[FLAG_SPACEZAP]) row_data = ct2_sz;
				else if (game_flags[FLAG_WOW]) row_data = ct2_ww;
				else if (game_flags[FLAG_GORF]) row_data = ct2_gf;
			end
			// DIP bank 3 regardless of game
			COL_CT3: row_data = dip3;
			default: row_data = ROW_IDLE;
		endcase
	end

endmodule

// ==== hdl/astro_input_top.sv ====
// Astrocade player input path
`timescale 1ns/10ps

module astro_input_top import astro_cfg_pkg::*, astro_input_pkg::*; (
	input  logic       clk_sys,
	input  logic       reset,
	input  logic       dl_wr,
	input  logic [7:0] dl_index,
	input  dl_addr_t   dl_addr,
	input  dl_data_t   dl_data,
	input  ps2_event_t ps2_key,
	input  joy_word_t  joy_p1,
	input  joy_word_t  joy_p2,
	input  analog_t    analog_a,
	input  analog_t    analog_b,
	input  logic       speech_busy,
	input  col_t       col_select,
	output row_t       row_data
);

	game_flags_t             game_flags;
	dip_byte_t               dip0, dip2, dip3;
	zone_t    [NUM_AXES-1:0] zones;
	wow_dir_t [NUM_AXES-1:0] axis_dirs;

	// Keyboard and joystick buttons to the matrix
	player_buttons_if btns_if ();

	game_config game_config_i (
		.clk_sys, .reset, .dl_wr, .dl_index, .dl_addr, .dl_data,
		.game_flags, .dip0, .dip2, .dip3
	);

	key_decoder key_decoder_i (
		.clk_sys, .reset, .ps2_key, .joy_p1, .joy_p2,
		.btns (btns_if.src)
	);

	paddle_shaper paddle_shaper_i (
		.clk_sys, .reset, .analog_a, .analog_b, .zones
	);

	// One mapper per stick axis, order set by the shaper
	for (genvar i = 0; i < NUM_AXES; i++) begin : g_axis
		wow_axis_mapper mapper_i (
			.clk_sys,
			.reset,
			.zone (zones[i]),
			.dir  (axis_dirs[i])
		);
	end

	switch_matrix switch_matrix_i (
		.game_flags, .dip0, .dip2, .dip3, .speech_busy, .col_select,
		.axis_dirs,
		.btns (btns_if.dst),
		.row_data
	);

endmodule

// ==== dv/astro_input_tb.sv ====
// Astrocade input path testbench
`timescale 1ns/10ps

module astro_input_tb import astro_cfg_pkg::*, astro_input_pkg::*; ();

	localparam int CLK_PERIOD   = 10;
	localparam int RESET_CYCLES = 16;
	// Run length budget in cycles for checks and strobes
	localparam int NUM_CHECKS   = 178;
	localparam int CHECK_CYCLES = 5;
	localparam int NUM_STROBES  = 64;
	localparam int TEST_CYCLES  = RESET_CYCLES + 2 + NUM_CHECKS * CHECK_CYCLES + NUM_STROBES;

	// Mapped keys with index 0 at the right
	localparam logic [17:0][8:0] KEY_TABLE = {
		KEY_S, KEY_A, KEY_G, KEY_D, KEY_F, KEY_R, KEY_5, KEY_F3, KEY_2,
		KEY_F2, KEY_1, KEY_F1, KEY_SPACE, KEY_CTRL, KEY_RIGHT, KEY_LEFT, KEY_DOWN, KEY_UP
	};
	// Three kept games and one unknown mode
	localparam logic [3:0][7:0] MODE_LIST = {8'h07, GAME_GORF, GAME_WOW, GAME_SPACEZAP};

	logic       clk_sys;
	logic       reset;
	logic       dl_wr;
	logic [7:0] dl_index;
	dl_addr_t   dl_addr;
	dl_data_t   dl_data;
	ps2_event_t ps2_key;
	joy_word_t  joy_p1;
	joy_word_t  joy_p2;
	analog_t    analog_a;
	analog_t    analog_b;
	logic       speech_busy;
	col_t       col_select;
	row_t       row_data;

	// Reference state
	integer     seed;
	logic       check_en;
	row_t       exp_row;
	logic [17:0] keys_m;
	joy_word_t  joy1_m;
	joy_word_t  joy2_m;
	analog_t    ana_a_m;
	analog_t    ana_b_m;
	logic       speech_m;
	game_id_t   game_m;
	dip_byte_t  dip_m [DIP_BANKS];

	astro_input_top dut_i (
		.clk_sys, .reset, .dl_wr, .dl_index, .dl_addr, .dl_data, .ps2_key,
		.joy_p1, .joy_p2, .analog_a, .analog_b, .speech_busy, .col_select, .row_data
	);

	// ============================================================
	// Checks
	// ============================================================

	a_row_value: assert property (@(posedge clk_sys) disable iff (reset)
		check_en |-> row_data == exp_row)
	else begin
		$display("CHECK FAILED row_data=%h expected=%h",
			$sampled(row_data), $sampled(exp_row));
		$display("Simulation failed");
		$fatal(1, "Row byte mismatch");
	end

	// No game while in reset
	a_reset_idle: assert property (@(posedge clk_sys)
		reset && (col_select != COL_CT3) |-> row_data == ROW_IDLE)
	else begin
		$display("CHECK FAILED row_data=%h expected=%h", $sampled(row_data), ROW_IDLE);
		$display("Simulation failed");
		$fatal(1, "Row byte not idle in reset");
	end

	// ============================================================
	// Reference model
	// ============================================================

	// Direction bits {move, dir1, dir0} from the centred zone
	function automatic wow_dir_t axis_model(input logic [7:0] raw, input logic is_y);
		logic [7:0] centred;
		zone_t      zone;
		centred = is_y ? (~raw + 8'd128) : (raw + 8'd128);
		zone    = centred[7:5];
		return {(zone == 3'd0) || (zone == 3'd7), zone >= 3'd6, zone <= 3'd1};
	endfunction

	function automatic row_t model_row(input col_t col);
		btn_t       b1, b2;
		logic       s1, s2, coin;
		logic [3:0] d1, d2;
		wow_dir_t   y1, x1, y2, x2;
		row_t       r;
		// fire_b, fire, up, down, left, right
		b1 = {keys_m[5], keys_m[4], keys_m[0], keys_m[1], keys_m[2], keys_m[3]} | joy1_m[5:0];
		b2 = {keys_m[17], keys_m[16], keys_m[12], keys_m[13], keys_m[14], keys_m[15]}
			| joy2_m[5:0];
		s1   = keys_m[6] | keys_m[7] | joy1_m[JOY_START1];
		s2   = keys_m[8] | keys_m[9] | joy1_m[JOY_START2];
		coin = keys_m[10] | keys_m[11] | joy1_m[JOY_COIN];
		d1 = ~{b1[BTN_RIGHT], b1[BTN_LEFT], b1[BTN_DOWN], b1[BTN_UP]};
		d2 = ~{b2[BTN_RIGHT], b2[BTN_LEFT], b2[BTN_DOWN], b2[BTN_UP]};
		y1 = axis_model(ana_a_m[15:8], 1'b1);
		x1 = axis_model(ana_a_m[7:0], 1'b0);
		y2 = axis_model(ana_b_m[15:8], 1'b1);
		x2 = axis_model(ana_b_m[7:0], 1'b0);
		r = ROW_IDLE;
		if (col == COL_CT3) begin
			r = dip_m[3];
		end else if (game_m == GAME_SPACEZAP) begin
			case (col)
				COL_CT0: r = {2'b11, ~s2, ~s1, dip_m[2][1], 1'b1, ~coin, 1'b1};
				COL_CT1: r = {3'b111, ~b2[BTN_FIRE], d2};
				COL_CT2: r = {2'b11, dip_m[2][0], ~b1[BTN_FIRE], d1};
				default: ;
			endcase
		end else if (game_m == GAME_WOW) begin
			// Stick mode takes right, left, down and up from the X and Y mappers
			case (col)
				COL_CT0: r = {dip_m[2][2], ~s2, ~s1, 1'b1,
					dip_m[2][1], 1'b1, ~coin, 1'b1};
				COL_CT1: r = dip_m[0][1] ?
					{2'b11, ~b2[BTN_FIRE], ~(y2[2] | x2[2]), ~x2[1], ~x2[0], ~y2[0], ~y2[1]} :
					{2'b11, ~b2[BTN_FIRE], b2[BTN_FIRE_B], d2};
				COL_CT2: r = dip_m[0][0] ?
					{speech_m, 1'b1, ~b1[BTN_FIRE], ~(y1[2] | x1[2]),
						~x1[1], ~x1[0], ~y1[0], ~y1[1]} :
					{speech_m, 1'b1, ~b1[BTN_FIRE], b1[BTN_FIRE_B], d1};
				default: ;
			endcase
		end else if (game_m == GAME_GORF) begin
			case (col)
				COL_CT0: r = {dip_m[2][2], dip_m[2][0], ~s2, ~s1,
					1'b1, dip_m[2][1], ~coin, 1'b1};
				COL_CT1: r = {3'b001, ~b2[BTN_FIRE], d2};
				COL_CT2: r = {speech_m, 2'b01, ~b1[BTN_FIRE], d1};
				default: ;
			endcase
		end
		return r;
	endfunction

	// ============================================================
	// Stimulus tasks
	// ============================================================

	task automatic dl_write(input logic [7:0] index, input dl_addr_t addr,
		input dl_data_t data);
		dl_wr    <= 1'b1;
		dl_index <= index;
		dl_addr  <= addr;
		dl_data  <= data;
		@(posedge clk_sys);
		dl_wr <= 1'b0;
		if (index == IDX_MODE) game_m = data[7:0];
		else if ((index == IDX_DIP) && (addr < 25'd8)) dip_m[addr[2:0]] = data[7:0];
	endtask

	// One PS/2 event flips the toggle bit
	task automatic press_key(input int idx, input logic pressed);
		ps2_key <= {~ps2_key[PS2_TOGGLE], pressed, KEY_TABLE[idx]};
		keys_m[idx] = pressed;
		@(posedge clk_sys);
	endtask

	// Select a column, let the path settle, arm the check for one edge
	task automatic check_col(input col_t col);
		row_t exp;
		exp = model_row(col);
		col_select <= col;
		repeat (4) @(posedge clk_sys);
		exp_row  <= exp;
		check_en <= 1'b1;
		@(posedge clk_sys);
		check_en <= 1'b0;
	endtask

	task automatic random_joysticks();
		joy1_m = 9'($random(seed) & $random(seed));
		joy2_m = 9'($random(seed) & $random(seed));
		joy_p1 <= joy1_m;
		joy_p2 <= joy2_m;
	endtask

	// ============================================================
	// Clock, watchdog, sequence
	// ============================================================

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("Watchdog timeout, the tests did not finish in time");
		$display("Simulation failed");
		$fatal(1, "Watchdog expired");
	end

	initial begin
		seed     = 18054;
		check_en = 1'b0;
		exp_row  = ROW_IDLE;
		keys_m   = '0;
		joy1_m   = '0;
		joy2_m   = '0;
		ana_a_m  = '0;
		ana_b_m  = '0;
		speech_m = 1'b0;
		game_m   = '0;
		for (int i = 0; i < DIP_BANKS; i++) dip_m[i] = '0;
		reset       = 1'b1;
		dl_wr       = 1'b0;
		dl_index    = '0;
		dl_addr     = '0;
		dl_data     = '0;
		ps2_key     = '0;
		joy_p1      = '0;
		joy_p2      = '0;
		analog_a    = '0;
		analog_b    = '0;
		speech_busy = 1'b0;
		col_select  = COL_CT0;
		repeat (RESET_CYCLES) @(posedge clk_sys);
		reset <= 1'b0;
		@(posedge clk_sys);

		// Idle rows and bank 3 readable without a game
		check_col(COL_CT0);
		check_col(COL_CT1);
		check_col(COL_CT2);
		check_col(8'h10);
		check_col(COL_CT3);
		dl_write(IDX_DIP, 25'd3, dl_data_t'($random(seed)));
		// Address 11 is out of range and must not alias bank 3
		dl_write(IDX_DIP, 25'd11, dl_data_t'($random(seed)));
		check_col(COL_CT3);

		// Game selection with random DIP bytes
		for (int m = 0; m < 4; m++) begin
			dl_write(IDX_DIP, 25'd2, dl_data_t'($random(seed)));
			dl_write(IDX_MODE, '0, dl_data_t'(MODE_LIST[m]));
			check_col(COL_CT0);
			check_col(COL_CT3);
		end

		// Space Zap with every key pressed then released
		dl_write(IDX_MODE, '0, dl_data_t'(GAME_SPACEZAP));
		for (int p = 1; p >= 0; p--) begin
			for (int i = 0; i < 18; i++) begin
				press_key(i, p[0]);
				random_joysticks();
				check_col(COL_CT0);
				check_col(COL_CT1);
				check_col(COL_CT2);
			end
		end
		joy1_m = '0;
		joy2_m = '0;
		joy_p1 <= '0;
		joy_p2 <= '0;

		// Wizard of Wor with both sticks mapped
		dl_write(IDX_DIP, 25'd0, 16'h0003);
		dl_write(IDX_MODE, '0, dl_data_t'(GAME_WOW));
		for (int n = 0; n < 24; n++) begin
			ana_a_m  = analog_t'($random(seed));
			ana_b_m  = analog_t'($random(seed));
			speech_m = 1'($random(seed));
			analog_a    <= ana_a_m;
			analog_b    <= ana_b_m;
			speech_busy <= speech_m;
			check_col(COL_CT1);
			check_col(COL_CT2);
		end

		// Gorf speech flag
		dl_write(IDX_MODE, '0, dl_data_t'(GAME_GORF));
		for (int b = 0; b < 2; b++) begin
			speech_m = b[0];
			speech_busy <= speech_m;
			check_col(COL_CT1);
			check_col(COL_CT2);
		end

		// Wizard of Wor key mode keeps fire_b active high
		dl_write(IDX_DIP, 25'd0, 16'h0000);
		dl_write(IDX_MODE, '0, dl_data_t'(GAME_WOW));
		press_key(17, 1'b1);
		press_key(5, 1'b1);
		check_col(COL_CT1);
		check_col(COL_CT2);
		press_key(17, 1'b0);
		press_key(5, 1'b0);
		check_col(COL_CT1);
		check_col(COL_CT2);

		$display("Simulation completed successfully");
		$finish;
	end

endmodule

// ==== astro_input.f ====
hdl/astro_cfg_pkg.sv
hdl/astro_input_pkg.sv
hdl/player_buttons_if.sv
hdl/game_config.sv
hdl/key_decoder.sv
hdl/paddle_shaper.sv
hdl/wow_axis_mapper.sv
hdl/switch_matrix.sv
hdl/astro_input_top.sv
dv/astro_input_tb.sv

// ==== Bender.yml ====
package:
  name: astro_input

sources:
  - hdl/astro_cfg_pkg.sv
  - hdl/astro_input_pkg.sv
  - hdl/player_buttons_if.sv
  - hdl/game_config.sv
  - hdl/key_decoder.sv
  - hdl/paddle_shaper.sv
  - hdl/wow_axis_mapper.sv
  - hdl/switch_matrix.sv
  - hdl/astro_input_top.sv
  - target: simulation
    files:
      - dv/astro_input_tb.sv
